//--- rtl/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Word width of registers, ALU and memory port
`define CPU_DATA_WIDTH 32

`define CPU_REG_COUNT 8                 // Register h is the last one

`define CPU_RESET_PC 32'h0000_0000

`endif

//--- rtl/cpu_pkg.sv
`include "cpu_config.svh"
`default_nettype none

package cpu_pkg;

    typedef enum logic [6:0]
    {
        op_nop       = 7'd0,
        op_add       = 7'd1,
        op_sub       = 7'd2,
        op_and       = 7'd3,
        op_or        = 7'd4,
        op_xor       = 7'd5,
        op_compare   = 7'd6,            // Flag only
        op_load_low  = 7'd7,
        op_load_high = 7'd8,
        op_load      = 7'd9,            // Address from register h
        op_store     = 7'd10,
        op_jump      = 7'd11,
        op_branch    = 7'd12,           // Taken on flag of source a
        op_halt      = 7'd13
    } opcode_t;

    typedef enum logic [1:0]
    {
        state_fetch,
        state_latch,
        state_execute,
        state_load_wait
    } state_t;

    typedef logic [$clog2(`CPU_REG_COUNT)-1:0] reg_index_t;

endpackage

`default_nettype wire

//--- rtl/register_file.sv
`include "cpu_config.svh"
`default_nettype none

module register_file
(
    input  wire                          clock,
    input  wire                          reset,
    input  wire cpu_pkg::reg_index_t     read_index_a,
    input  wire cpu_pkg::reg_index_t     read_index_b,
    input  wire cpu_pkg::reg_index_t     write_index,
    input  wire                          reg_write,
    input  wire [`CPU_DATA_WIDTH-1:0]    write_value,
    input  wire                          flag_write,
    input  wire                          write_flag,
    output logic [`CPU_DATA_WIDTH-1:0]   read_value_a,
    output logic [`CPU_DATA_WIDTH-1:0]   read_value_b,
    output logic [`CPU_DATA_WIDTH-1:0]   read_value_h,
    output logic                         read_flag_a,
    output logic                         read_flag_b
);

    logic [`CPU_DATA_WIDTH-1:0] registers [`CPU_REG_COUNT];
    logic [`CPU_REG_COUNT-1:0]  flags;

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            for (int i = 0; i < `CPU_REG_COUNT; i++)
            begin
                registers[i] <= '0;
            end
            flags <= '0;
        end
        else
        begin
            if (reg_write)
                registers[write_index] <= write_value;
            if (flag_write)                                 // Independent of reg_write
                flags[write_index] <= write_flag;
        end
    end

    assign read_value_a = registers[read_index_a];
    assign read_value_b = registers[read_index_b];
    assign read_flag_a  = flags[read_index_a];
    assign read_flag_b  = flags[read_index_b];

    // Dedicated port for the memory pointer
    assign read_value_h = registers[`CPU_REG_COUNT-1];

endmodule

`default_nettype wire

//--- rtl/alu.sv
`include "cpu_config.svh"
`default_nettype none

module alu
(
    input  wire cpu_pkg::opcode_t        opcode,
    input  wire [`CPU_DATA_WIDTH-1:0]    operand_a,
    input  wire [`CPU_DATA_WIDTH-1:0]    operand_b,
    input  wire [`CPU_DATA_WIDTH-1:0]    old_value,
    input  wire                          flag_a,
    input  wire [15:0]                   immediate,
    output logic [`CPU_DATA_WIDTH-1:0]   result,
    output logic                         result_flag,
    output logic                         branch_taken
);

    logic [`CPU_DATA_WIDTH:0] wide_sum;
    logic [`CPU_DATA_WIDTH:0] wide_difference;

    assign wide_sum        = {1'b0, operand_a} + {1'b0, operand_b};
    assign wide_difference = {1'b0, operand_a} - {1'b0, operand_b};   // Top bit is the borrow

    always_comb
    begin
        result      = old_value;
        result_flag = 1'b0;
        case (opcode)
            cpu_pkg::op_add:
            begin
                result      = wide_sum[`CPU_DATA_WIDTH-1:0];
                result_flag = wide_sum[`CPU_DATA_WIDTH];
            end
            cpu_pkg::op_sub:
            begin
                result      = wide_difference[`CPU_DATA_WIDTH-1:0];
                result_flag = wide_difference[`CPU_DATA_WIDTH];
            end
            cpu_pkg::op_and:
            begin
                result      = operand_a & operand_b;
                result_flag = ~|result;                     // Zero flag
            end
            cpu_pkg::op_or:
            begin
                result      = operand_a | operand_b;
                result_flag = ~|result;
            end
            cpu_pkg::op_xor:
            begin
                result      = operand_a ^ operand_b;
                result_flag = ~|result;
            end
            cpu_pkg::op_compare:
            begin
                result_flag = operand_a < operand_b;        // Unsigned
            end
            cpu_pkg::op_load_low:
            begin
                result = {old_value[`CPU_DATA_WIDTH-1:16], immediate};
            end
            cpu_pkg::op_load_high:
            begin
                result = {immediate, old_value[15:0]};
            end
            default:
            begin
                result = old_value;
            end
        endcase
    end

    assign branch_taken = (opcode == cpu_pkg::op_jump)
                        || ((opcode == cpu_pkg::op_branch) && flag_a);

endmodule

`default_nettype wire

//--- rtl/cpu_control.sv
`include "cpu_config.svh"
`default_nettype none

module cpu_control
(
    input  wire                          clock,
    input  wire                          reset,
    input  wire [`CPU_DATA_WIDTH-1:0]    data,
    input  wire [`CPU_DATA_WIDTH-1:0]    result,
    input  wire                          result_flag,
    input  wire                          branch_taken,
    input  wire [`CPU_DATA_WIDTH-1:0]    read_value_a,
    input  wire [`CPU_DATA_WIDTH-1:0]    read_value_h,
    output logic [`CPU_DATA_WIDTH-1:0]   address,
    output logic [`CPU_DATA_WIDTH-1:0]   datao,
    output logic                         rw,
    output logic                         halted,
    output cpu_pkg::opcode_t             opcode,
    output cpu_pkg::reg_index_t          read_index_a,
    output cpu_pkg::reg_index_t          read_index_b,
    output cpu_pkg::reg_index_t          write_index,
    output logic [15:0]                  immediate,
    output logic                         reg_write,
    output logic [`CPU_DATA_WIDTH-1:0]   write_value,
    output logic                         flag_write,
    output logic                         write_flag
);

    cpu_pkg::state_t            state;
    cpu_pkg::opcode_t           fetched_opcode;
    logic [`CPU_DATA_WIDTH-1:0] pc;
    logic [`CPU_DATA_WIDTH-1:0] instruction;
    logic [`CPU_DATA_WIDTH-1:0] next_pc;
    logic                       immediate_merge;

    assign opcode          = cpu_pkg::opcode_t'(instruction[6:0]);
    assign fetched_opcode  = cpu_pkg::opcode_t'(data[6:0]);     // Valid during latch
    assign read_index_a    = instruction[9:7];
    assign write_index     = instruction[15:13];
    assign immediate       = instruction[31:16];

    // Immediate loads read the destination on port b so the ALU can merge halves
    assign immediate_merge = (opcode == cpu_pkg::op_load_low) || (opcode == cpu_pkg::op_load_high);
    assign read_index_b    = immediate_merge ? instruction[15:13] : instruction[12:10];

    assign next_pc = branch_taken ? {{(`CPU_DATA_WIDTH-16){1'b0}}, immediate}
                                  : pc + `CPU_DATA_WIDTH'(1);

    assign datao       = read_value_a;
    assign write_value = (state == cpu_pkg::state_load_wait) ? data : result;
    assign write_flag  = result_flag;
    assign halted      = (state == cpu_pkg::state_execute) && (opcode == cpu_pkg::op_halt);

    always_comb
    begin
        reg_write  = 1'b0;
        flag_write = 1'b0;
        if (state == cpu_pkg::state_execute)
        begin
            case (opcode)
                cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_and,
                cpu_pkg::op_or, cpu_pkg::op_xor:
                begin
                    reg_write  = 1'b1;
                    flag_write = 1'b1;
                end
                cpu_pkg::op_compare:
                    flag_write = 1'b1;
                cpu_pkg::op_load_low, cpu_pkg::op_load_high:
                    reg_write = 1'b1;
                default:
                    reg_write = 1'b0;
            endcase
        end
        else if (state == cpu_pkg::state_load_wait)
            reg_write = 1'b1;                               // Memory word for op_load
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state       <= cpu_pkg::state_fetch;
            pc          <= `CPU_RESET_PC;
            address     <= `CPU_RESET_PC;
            rw          <= 1'b0;
            instruction <= '0;
        end
        else
        begin
            case (state)
                cpu_pkg::state_fetch:
                    state <= cpu_pkg::state_latch;          // Memory samples pc here
                cpu_pkg::state_latch:
                begin
                    instruction <= data;
                    state       <= cpu_pkg::state_execute;
                    if ((fetched_opcode == cpu_pkg::op_load) || (fetched_opcode == cpu_pkg::op_store))
                        address <= read_value_h;
                    rw <= (fetched_opcode == cpu_pkg::op_store);
                end
                cpu_pkg::state_execute:
                begin
                    rw <= 1'b0;
                    if (opcode != cpu_pkg::op_halt)
                    begin
                        pc      <= next_pc;
                        address <= next_pc;
                        state   <= (opcode == cpu_pkg::op_load) ? cpu_pkg::state_load_wait
                                                                : cpu_pkg::state_fetch;
                    end
                end
                cpu_pkg::state_load_wait:
                    state <= cpu_pkg::state_fetch;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/cpu.sv
`include "cpu_config.svh"
`default_nettype none

module cpu
(
    input  wire                          clock,
    input  wire                          reset,
    input  wire [`CPU_DATA_WIDTH-1:0]    data,
    output logic [`CPU_DATA_WIDTH-1:0]   datao,
    output logic [`CPU_DATA_WIDTH-1:0]   address,
    output logic                         rw,
    output logic                         halted
);

    cpu_pkg::opcode_t           opcode;
    cpu_pkg::reg_index_t        read_index_a;
    cpu_pkg::reg_index_t        read_index_b;
    cpu_pkg::reg_index_t        write_index;
    logic [15:0]                immediate;
    logic [`CPU_DATA_WIDTH-1:0] read_value_a;
    logic [`CPU_DATA_WIDTH-1:0] read_value_b;
    logic [`CPU_DATA_WIDTH-1:0] read_value_h;
    logic                       read_flag_a;
    logic [`CPU_DATA_WIDTH-1:0] result;
    logic                       result_flag;
    logic                       branch_taken;
    logic                       reg_write;
    logic [`CPU_DATA_WIDTH-1:0] write_value;
    logic                       flag_write;
    logic                       write_flag;

    cpu_control control_inst
    (
        .clock        (clock),
        .reset        (reset),
        .data         (data),
        .result       (result),
        .result_flag  (result_flag),
        .branch_taken (branch_taken),
        .read_value_a (read_value_a),
        .read_value_h (read_value_h),
        .address      (address),
        .datao        (datao),
        .rw           (rw),
        .halted       (halted),
        .opcode       (opcode),
        .read_index_a (read_index_a),
        .read_index_b (read_index_b),
        .write_index  (write_index),
        .immediate    (immediate),
        .reg_write    (reg_write),
        .write_value  (write_value),
        .flag_write   (flag_write),
        .write_flag   (write_flag)
    );

    register_file register_file_inst
    (
        .clock        (clock),
        .reset        (reset),
        .read_index_a (read_index_a),
        .read_index_b (read_index_b),
        .write_index  (write_index),
        .reg_write    (reg_write),
        .write_value  (write_value),
        .flag_write   (flag_write),
        .write_flag   (write_flag),
        .read_value_a (read_value_a),
        .read_value_b (read_value_b),
        .read_value_h (read_value_h),                   // Memory pointer for load and store
        .read_flag_a  (read_flag_a),
        .read_flag_b  ()
    );

    // Port b carries the destination for immediate loads, so it doubles as old_value
    alu alu_inst
    (
        .opcode       (opcode),
        .operand_a    (read_value_a),
        .operand_b    (read_value_b),
        .old_value    (read_value_b),
        .flag_a       (read_flag_a),
        .immediate    (immediate),
        .result       (result),
        .result_flag  (result_flag),
        .branch_taken (branch_taken)
    );

endmodule

`default_nettype wire

//--- testbench/clock_gen.sv
`default_nettype none

module clock_gen
(
    output logic clock
);
    timeunit 1ns;
    timeprecision 1ps;

    initial
    begin
        clock = 1'b0;
        forever
            #4 clock = ~clock;                      // 8 ns period
    end

endmodule

`default_nettype wire

//--- testbench/memory_model.sv
`include "cpu_config.svh"
`default_nettype none

module memory_model
(
    input  wire                         clock,
    input  wire [`CPU_DATA_WIDTH-1:0]   address,
    input  wire [`CPU_DATA_WIDTH-1:0]   datao,
    input  wire                         rw,
    output wire [`CPU_DATA_WIDTH-1:0]   data
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [`CPU_DATA_WIDTH-1:0] words [256];
    logic [`CPU_DATA_WIDTH-1:0] read_word_q = '0;
    logic                       fill_request = 1'b0;
    logic                       load_request = 1'b0;
    logic [7:0]                 load_index = '0;
    logic [`CPU_DATA_WIDTH-1:0] load_value = '0;

    assign data = read_word_q;

    always @(posedge clock)
    begin
        if (fill_request)
        begin
            for (int i = 0; i < 256; i++)
                words[i[7:0]] <= 32'h5a5a_0000 + i;     // Distinct word per address
        end
        if (load_request)
            words[load_index] <= load_value;
        if (rw)
            words[address[7:0]] <= datao;
        read_word_q <= words[address[7:0]];             // One cycle read latency
    end

    task automatic clear_words();
        @(posedge clock);
        fill_request <= 1'b1;
        @(posedge clock);
        fill_request <= 1'b0;
    endtask

    task automatic write_word(input logic [7:0] index, input logic [`CPU_DATA_WIDTH-1:0] value);
        @(posedge clock);
        load_request <= 1'b1;
        load_index   <= index;
        load_value   <= value;
        @(posedge clock);
        load_request <= 1'b0;
    endtask

    function automatic logic [`CPU_DATA_WIDTH-1:0] read_word(input logic [7:0] index);
        return words[index];
    endfunction

endmodule

`default_nettype wire

//--- testbench/cpu_tb.sv
`include "cpu_config.svh"
`default_nettype none

module cpu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int test_count = 6;
    localparam int halt_limit = 200;                // Cycles allowed per program

    wire                        clock;
    logic                       reset = 1'b1;
    wire [`CPU_DATA_WIDTH-1:0]  data;
    wire [`CPU_DATA_WIDTH-1:0]  datao;
    wire [`CPU_DATA_WIDTH-1:0]  address;
    wire                        rw;
    wire                        halted;
    integer                     seed = 32'haf23890b;
    int                         errors = 0;
    int                         failed_tests = 0;
    logic [31:0]                program_words [$];

    clock_gen clock_inst
    (
        .clock (clock)
    );

    memory_model memory_inst
    (
        .clock   (clock),
        .address (address),
        .datao   (datao),
        .rw      (rw),
        .data    (data)
    );

    cpu cpu_inst
    (
        .clock   (clock),
        .reset   (reset),
        .data    (data),
        .datao   (datao),
        .address (address),
        .rw      (rw),
        .halted  (halted)
    );

    function automatic void emit(input cpu_pkg::opcode_t op, input logic [2:0] dest,
                                 input logic [2:0] src_a, input logic [2:0] src_b,
                                 input logic [15:0] imm);
        program_words.push_back({imm, dest, src_b, src_a, op});
    endfunction

    function automatic void set_reg(input logic [2:0] index, input logic [31:0] value);
        emit(cpu_pkg::op_load_low, index, 3'd0, 3'd0, value[15:0]);
        emit(cpu_pkg::op_load_high, index, 3'd0, 3'd0, value[31:16]);
    endfunction

    function automatic void store_reg(input logic [2:0] index, input logic [7:0] word);
        emit(cpu_pkg::op_load_low, 3'd7, 3'd0, 3'd0, {8'd0, word});    // Point h at word
        emit(cpu_pkg::op_store, 3'd0, index, 3'd0, 16'd0);
    endfunction

    // Word gets 2 when the flag of index is set, else 1; uses r6
    function automatic void store_flag(input logic [2:0] index, input logic [7:0] word);
        logic [15:0] here;
        here = 16'(program_words.size());
        emit(cpu_pkg::op_branch, 3'd0, index, 3'd0, here + 16'd3);
        emit(cpu_pkg::op_load_low, 3'd6, 3'd0, 3'd0, 16'd1);
        emit(cpu_pkg::op_jump, 3'd0, 3'd0, 3'd0, here + 16'd4);
        emit(cpu_pkg::op_load_low, 3'd6, 3'd0, 3'd0, 16'd2);
        store_reg(3'd6, word);
    endfunction

    task automatic check_memory(input logic [7:0] index, input logic [31:0] expected);
        logic [31:0] actual;
        actual = memory_inst.read_word(index);
        if (actual !== expected)
        begin
            $display("[FAIL] %0t ns memory[%0d] expected %h actual %h",
                     $time, index, expected, actual);
            errors++;
        end
    endtask

    task automatic load_program();
        emit(cpu_pkg::op_halt, 3'd0, 3'd0, 3'd0, 16'd0);
        @(posedge clock);
        reset <= 1'b1;                              // DUT stays idle while memory is loaded
        memory_inst.clear_words();
        foreach (program_words[i])
            memory_inst.write_word(8'(i), program_words[i]);
    endtask

    task automatic run_program();
        int cycles;
        repeat (3)
        begin
            @(negedge clock);
            if (rw !== 1'b0)
            begin
                $display("[FAIL] %0t ns rw expected 0 actual %b", $time, rw);
                errors++;
            end
        end
        @(posedge clock);
        reset <= 1'b0;
        cycles = 0;
        while (halted !== 1'b1 && cycles < halt_limit)
        begin
            @(negedge clock);
            cycles++;
        end
        if (halted !== 1'b1)
        begin
            $display("Program did not halt within %0d cycles", halt_limit);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before)
            $display("%s: ok", name);
        else
        begin
            $display("%s: %0d errors", name, errors - errors_before);
            failed_tests++;
        end
    endtask

    task automatic test_immediate_store();
        int          errors_before;
        logic [31:0] value;
        errors_before = errors;
        value = $random(seed);
        program_words.delete();
        set_reg(3'd1, value);
        store_reg(3'd1, 8'd128);
        load_program();
        run_program();
        check_memory(8'd128, value);
        report_test("immediate_store", errors_before);
    endtask

    task automatic test_arithmetic();
        int          errors_before;
        logic [31:0] a;
        logic [31:0] b;
        logic [32:0] sum;
        errors_before = errors;
        a = $random(seed);
        b = $random(seed);
        sum = {1'b0, a} + {1'b0, b};
        program_words.delete();
        set_reg(3'd1, a);
        set_reg(3'd2, b);
        emit(cpu_pkg::op_add, 3'd3, 3'd1, 3'd2, 16'd0);
        emit(cpu_pkg::op_sub, 3'd4, 3'd1, 3'd2, 16'd0);
        store_reg(3'd3, 8'd128);
        store_reg(3'd4, 8'd129);
        store_flag(3'd3, 8'd130);
        store_flag(3'd4, 8'd131);
        load_program();
        run_program();
        check_memory(8'd128, sum[31:0]);
        check_memory(8'd129, a - b);
        check_memory(8'd130, sum[32] ? 32'd2 : 32'd1);   // Carry out
        check_memory(8'd131, (a < b) ? 32'd2 : 32'd1);   // Borrow
        report_test("arithmetic", errors_before);
    endtask

    task automatic test_logic();
        int          errors_before;
        logic [31:0] a;
        logic [31:0] b;
        errors_before = errors;
        a = $random(seed);
        b = $random(seed);
        program_words.delete();
        set_reg(3'd1, a);
        set_reg(3'd2, b);
        emit(cpu_pkg::op_and, 3'd3, 3'd1, 3'd2, 16'd0);
        emit(cpu_pkg::op_or, 3'd4, 3'd1, 3'd2, 16'd0);
        emit(cpu_pkg::op_xor, 3'd5, 3'd1, 3'd2, 16'd0);
        emit(cpu_pkg::op_xor, 3'd2, 3'd1, 3'd1, 16'd0);
        store_reg(3'd3, 8'd128);
        store_reg(3'd4, 8'd129);
        store_reg(3'd5, 8'd130);
        store_reg(3'd2, 8'd131);
        store_flag(3'd5, 8'd132);
        store_flag(3'd2, 8'd133);
        load_program();
        run_program();
        check_memory(8'd128, a & b);
        check_memory(8'd129, a | b);
        check_memory(8'd130, a ^ b);
        check_memory(8'd131, 32'd0);
        check_memory(8'd132, ((a ^ b) == 32'd0) ? 32'd2 : 32'd1);
        check_memory(8'd133, 32'd2);                     // Self xor is always zero
        report_test("logic", errors_before);
    endtask

    task automatic test_memory_load();
        int          errors_before;
        logic [31:0] value;
        errors_before = errors;
        value = $random(seed);
        program_words.delete();
        emit(cpu_pkg::op_load_low, 3'd7, 3'd0, 3'd0, 16'd140);
        emit(cpu_pkg::op_load, 3'd1, 3'd0, 3'd0, 16'd0);
        emit(cpu_pkg::op_load_low, 3'd2, 3'd0, 3'd0, 16'd1);
        emit(cpu_pkg::op_add, 3'd3, 3'd1, 3'd2, 16'd0);
        store_reg(3'd3, 8'd128);
        load_program();
        memory_inst.write_word(8'd140, value);
        run_program();
        check_memory(8'd128, value + 32'd1);
        report_test("memory_load", errors_before);
    endtask

    task automatic test_control_flow();
        int          errors_before;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] untouched;
        errors_before = errors;
        a = $random(seed);
        b = $random(seed);
        program_words.delete();
        emit(cpu_pkg::op_load_low, 3'd1, 3'd0, 3'd0, 16'd5);
        emit(cpu_pkg::op_jump, 3'd0, 3'd0, 3'd0, 16'(program_words.size() + 3));
        store_reg(3'd1, 8'd128);                         // Skipped by the jump
        set_reg(3'd2, a);
        set_reg(3'd3, b);
        emit(cpu_pkg::op_compare, 3'd4, 3'd2, 3'd3, 16'd0);
        emit(cpu_pkg::op_compare, 3'd5, 3'd3, 3'd2, 16'd0);
        store_flag(3'd4, 8'd129);
        store_flag(3'd5, 8'd131);
        store_reg(3'd1, 8'd130);
        load_program();
        untouched = memory_inst.read_word(8'd128);
        run_program();
        check_memory(8'd128, untouched);
        check_memory(8'd129, (a < b) ? 32'd2 : 32'd1);
        check_memory(8'd131, (b < a) ? 32'd2 : 32'd1);
        check_memory(8'd130, 32'd5);
        report_test("control_flow", errors_before);
    endtask

    task automatic test_reset_state();
        int errors_before;
        errors_before = errors;
        program_words.delete();
        for (int r = 0; r < 7; r++)
        begin
            set_reg(3'(r), 32'hffff_ffff);
            emit(cpu_pkg::op_add, 3'(r), 3'(r), 3'(r), 16'd0);   // Carry sets the flag
        end
        load_program();
        run_program();
        program_words.delete();
        for (int r = 0; r < 7; r++)
            store_reg(3'(r), 8'(128 + r));
        for (int r = 0; r < 7; r++)
            store_flag(3'(r), 8'(135 + r));
        load_program();
        run_program();
        for (int r = 0; r < 7; r++)
            check_memory(8'(128 + r), 32'd0);
        for (int r = 0; r < 7; r++)
            check_memory(8'(135 + r), 32'd1);            // Flags cleared by reset
        report_test("reset_state", errors_before);
    endtask

    initial
    begin
        test_immediate_store();
        test_arithmetic();
        test_logic();
        test_memory_load();
        test_control_flow();
        test_reset_state();
        $display("%0d tests, %0d failed, %0d errors", test_count, failed_tests, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

    initial
    begin
        #(test_count * 2000);
        $display("Timeout after %0d ns, the DUT did not finish the programs", test_count * 2000);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+rtl
rtl/cpu_pkg.sv
rtl/register_file.sv
rtl/alu.sv
rtl/cpu_control.sv
rtl/cpu.sv
testbench/clock_gen.sv
testbench/memory_model.sv
testbench/cpu_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0 --timescale 1ns/1ps
TOP       ?= cpu_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
PASS_TEXT := Regression passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run the regression"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
